//--- bench/l1_cache_assertions.sv
`default_nettype none

module l1_cache_assertions (
    input logic                   clk,
    input logic                   reset,
    input l1_cache_pkg::bus_req_t bus_req,
    input logic                   bus_req_valid,
    input logic                   bus_req_ready,
    input logic                   core_rsp_valid,
    input logic                   flush_valid
);

    // Request and payload hold until the arbiter grants
    assert property (@(posedge clk) disable iff (reset)
        bus_req_valid && !bus_req_ready |=> bus_req_valid && $stable(bus_req))
        else $error("bus request dropped or changed before grant");

    assert property (@(posedge clk) disable iff (reset)
        core_rsp_valid |=> !core_rsp_valid)
        else $error("core response valid high in two consecutive cycles");

    // First cycle out of reset
    assert property (@(posedge clk) $fell(reset) |-> !bus_req_valid && !flush_valid)
        else $error("bus request or flush active right after reset");

endmodule

`default_nettype wire

//--- bench/l1_cache_patterns.txt
# C op size uns addr wdata shared exp_bus exp_data exp_flush flush_addr flush_data
# S bus_op addr exp_hit exp_data exp_flush ; op 0 load 1 store, size 0/1/2 byte/half/word, bus 0 rd 1 upgr 2 rdx 3 none
C 0 2 0 00001004 00000000 0 0 5a5a1004 0 00000000 00000000
C 0 2 0 00001004 00000000 0 3 5a5a1004 0 00000000 00000000
C 1 0 0 00001005 000000ab 0 3 00000000 0 00000000 00000000
C 1 1 0 00001006 0000beef 0 3 00000000 0 00000000 00000000
C 0 2 0 00001004 00000000 0 3 beefab04 0 00000000 00000000
C 0 0 0 00001007 00000000 0 3 ffffffbe 0 00000000 00000000
C 0 1 1 00001006 00000000 0 3 0000beef 0 00000000 00000000
C 0 0 0 0000a0f0 00000000 0 0 fffffff0 0 00000000 00000000
C 0 0 1 0000a0f1 00000000 0 3 000000a0 0 00000000 00000000
C 0 1 0 0000a0f0 00000000 0 3 ffffa0f0 0 00000000 00000000
C 0 2 0 00002008 00000000 1 0 5a5a2008 0 00000000 00000000
C 1 2 0 00002008 12345678 0 1 00000000 0 00000000 00000000
C 0 2 0 00002008 00000000 0 3 12345678 0 00000000 00000000
C 1 1 0 0000300e 0000cafe 0 2 00000000 0 00000000 00000000
C 0 2 0 0000300c 00000000 0 3 cafe300c 0 00000000 00000000
S 0 00001004 1 beefab04 1
C 1 0 0 00001004 00000077 0 1 00000000 0 00000000 00000000
C 0 2 0 00001004 00000000 0 3 beefab77 0 00000000 00000000
S 2 0000300c 1 cafe300c 1
C 0 2 0 0000300c 00000000 1 0 cafe300c 0 00000000 00000000
S 0 00004010 0 00000000 0
S 1 0000300c 1 cafe300c 0
C 0 1 0 0000300e 00000000 0 0 ffffcafe 0 00000000 00000000
S 0 0000300c 1 cafe300c 0
C 0 2 0 00005008 00000000 0 0 5a5a5008 1 00002008 12345678
C 0 2 0 00002008 00000000 0 0 12345678 0 00000000 00000000
C 1 2 0 00009004 deadbeef 0 2 00000000 1 00001004 beefab77
C 0 2 0 00001004 00000000 1 0 beefab77 1 00009004 deadbeef
C 0 2 0 00009004 00000000 0 0 deadbeef 0 00000000 00000000

//--- bench/l1_cache_tb.sv
`default_nettype none
`include "l1_consts.svh"

module l1_cache_tb;
    import l1_cache_pkg::*;

    typedef struct packed {
        logic        is_snoop;
        logic [1:0]  op;          // Core op or bus op
        logic [1:0]  size;
        logic        uns;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        shared;
        logic [1:0]  exp_bus;
        logic [31:0] exp_data;
        logic        exp_hit;
        logic        exp_flush;
        logic [31:0] flush_addr;
        logic [31:0] flush_data;
    } step_t;

    logic       clk = 1'b0;
    logic       reset;
    core_req_t  core_req;
    logic       core_req_valid;
    logic       core_req_ready;
    core_rsp_t  core_rsp;
    logic       core_rsp_valid;
    bus_req_t   bus_req;
    logic       bus_req_valid;
    logic       bus_req_ready;
    bus_fill_t  bus_fill;
    logic       bus_fill_valid;
    snoop_req_t snoop_req;
    logic       snoop_valid;
    snoop_rsp_t snoop_rsp;
    flush_t     flush;
    logic       flush_valid;

    step_t       steps[$];
    logic [31:0] flushed_mem [logic [29:0]];   // Bus side memory of written back lines
    flush_t      last_flush;
    logic [1:0]  last_bus_op;
    logic [31:0] last_bus_addr;
    int          flush_count = 0;
    int          bus_count = 0;
    logic        loaded = 1'b0;
    logic        fill_shared = 1'b0;
    integer      seed = 32'h6bbe_1ce0;

    always #5 clk = ~clk;

    l1_cache_top UUT (.*);

    bind l1_cache_top l1_cache_assertions u_assertions (
        .clk            (clk),
        .reset          (reset),
        .bus_req        (bus_req),
        .bus_req_valid  (bus_req_valid),
        .bus_req_ready  (bus_req_ready),
        .core_rsp_valid (core_rsp_valid),
        .flush_valid    (flush_valid)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1);
    endtask

    // Memory content wins over the address based default
    function automatic logic [31:0] fill_word(input logic [29:0] line_addr);
        if (flushed_mem.exists(line_addr)) begin
            return flushed_mem[line_addr];
        end
        return {line_addr, 2'b00} ^ 32'h5a5a_0000;
    endfunction

    task automatic load_patterns;
        integer      fd;
        integer      code;
        integer      n;
        string       text;
        step_t       st;
        logic [31:0] f [11];
        fd = $fopen("bench/l1_cache_patterns.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open bench/l1_cache_patterns.txt");
        end
        while (!$feof(fd)) begin
            code = $fgets(text, fd);
            st = '0;
            if (code > 0 && text.len() > 0 && text.getc(0) == "C") begin
                n = $sscanf(text, "C %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                            f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
                if (n != 11) begin
                    report_failure("malformed core line in pattern file");
                end
                st.op         = f[0][1:0];
                st.size       = f[1][1:0];
                st.uns        = f[2][0];
                st.addr       = f[3];
                st.wdata      = f[4];
                st.shared     = f[5][0];
                st.exp_bus    = f[6][1:0];
                st.exp_data   = f[7];
                st.exp_flush  = f[8][0];
                st.flush_addr = f[9];
                st.flush_data = f[10];
                steps.push_back(st);
            end else if (code > 0 && text.len() > 0 && text.getc(0) == "S") begin
                n = $sscanf(text, "S %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4]);
                if (n != 5) begin
                    report_failure("malformed snoop line in pattern file");
                end
                st.is_snoop  = 1'b1;
                st.op        = f[0][1:0];
                st.addr      = f[1];
                st.exp_hit   = f[2][0];
                st.exp_data  = f[3];
                st.exp_flush = f[4][0];
                steps.push_back(st);
            end
        end
        $fclose(fd);
        if (steps.size() == 0) begin
            report_failure("pattern file holds no steps");
        end
    endtask

    task automatic issue_core_request(input int i);
        step_t st;
        int    flushes_before;
        int    bus_before;
        int    cycles;
        int    exp_flushes;
        st = steps[i];
        exp_flushes = st.exp_flush ? 1 : 0;
        @(posedge clk);
        #1;
        flushes_before = flush_count;
        bus_before     = bus_count;
        fill_shared    = st.shared;
        core_req.op               = mem_op_t'(st.op[0]);
        core_req.mask.size        = size_t'(st.size);
        core_req.mask.is_unsigned = st.uns;
        core_req.addr             = st.addr;
        core_req.wdata            = st.wdata;
        core_req_valid            = 1'b1;
        @(negedge clk);
        while (!core_req_ready) @(negedge clk);
        @(posedge clk);   // Handshake edge
        #1;
        core_req_valid = 1'b0;
        cycles = 1;
        @(negedge clk);
        while (!core_rsp_valid) begin
            @(negedge clk);
            cycles++;
        end
        assert (core_rsp.rdata == st.exp_data) else report_failure($sformatf(
            "MISMATCH step %0d core_rsp.rdata got %h expected %h", i, core_rsp.rdata,
            st.exp_data));
        if (st.exp_bus == `L1_BUS_NONE) begin
            assert (bus_count == bus_before) else report_failure($sformatf(
                "step %0d issued a bus request where none was expected", i));
            assert (cycles == 1) else report_failure($sformatf(
                "step %0d hit response came %0d cycles after acceptance", i, cycles));
        end else begin
            assert (bus_count == bus_before + 1) else report_failure($sformatf(
                "step %0d did not issue exactly one bus request", i));
            assert (last_bus_op == st.exp_bus) else report_failure($sformatf(
                "MISMATCH step %0d bus_req.op got %h expected %h", i, last_bus_op,
                st.exp_bus));
            assert (last_bus_addr == st.addr) else report_failure($sformatf(
                "MISMATCH step %0d bus_req.addr got %h expected %h", i, last_bus_addr,
                st.addr));
        end
        assert (flush_count - flushes_before == exp_flushes) else report_failure($sformatf(
            "MISMATCH step %0d flush_valid pulses got %h expected %h", i,
            flush_count - flushes_before, exp_flushes));
        if (st.exp_flush) begin
            assert ({last_flush.line_addr, 2'b00} == st.flush_addr) else report_failure(
                $sformatf("MISMATCH step %0d flush.line_addr got %h expected %h", i,
                {last_flush.line_addr, 2'b00}, st.flush_addr));
            assert (last_flush.data == st.flush_data) else report_failure($sformatf(
                "MISMATCH step %0d flush.data got %h expected %h", i, last_flush.data,
                st.flush_data));
        end
    endtask

    task automatic present_snoop(input int i);
        step_t st;
        st = steps[i];
        @(posedge clk);
        #1;
        snoop_req.op   = bus_op_t'(st.op);
        snoop_req.addr = st.addr;
        snoop_valid    = 1'b1;
        @(negedge clk);   // Response is combinational
        assert (!core_req_ready) else report_failure($sformatf(
            "step %0d core_req_ready stayed high during a snoop", i));
        assert (snoop_rsp.hit == st.exp_hit) else report_failure($sformatf(
            "MISMATCH step %0d snoop_rsp.hit got %h expected %h", i, snoop_rsp.hit,
            st.exp_hit));
        assert (snoop_rsp.data == st.exp_data) else report_failure($sformatf(
            "MISMATCH step %0d snoop_rsp.data got %h expected %h", i, snoop_rsp.data,
            st.exp_data));
        assert (flush_valid == st.exp_flush) else report_failure($sformatf(
            "MISMATCH step %0d flush_valid got %h expected %h", i, flush_valid,
            st.exp_flush));
        if (st.exp_flush) begin
            assert (flush.line_addr == st.addr[31:2]) else report_failure($sformatf(
                "MISMATCH step %0d flush.line_addr got %h expected %h", i, flush.line_addr,
                st.addr[31:2]));
            assert (flush.data == st.exp_data) else report_failure($sformatf(
                "MISMATCH step %0d flush.data got %h expected %h", i, flush.data,
                st.exp_data));
        end
        @(posedge clk);
        #1;
        snoop_valid = 1'b0;
    endtask

    // Outputs sampled mid cycle where they are settled
    always @(negedge clk) begin
        if (!reset && flush_valid) begin
            flushed_mem[flush.line_addr] = flush.data;
            last_flush  = flush;
            flush_count = flush_count + 1;
        end
    end

    initial begin : bus_model
        integer      delay;
        logic [29:0] line_addr;
        logic [1:0]  op;
        bus_req_ready  = 1'b0;
        bus_fill       = '0;
        bus_fill_valid = 1'b0;
        forever begin
            @(negedge clk);
            if (!reset && bus_req_valid) begin
                op            = bus_req.op;
                line_addr     = bus_req.addr[31:2];
                last_bus_op   = op;
                last_bus_addr = bus_req.addr;
                bus_count     = bus_count + 1;
                delay         = $random(seed) & 3;   // 0 to 3 wait cycles
                repeat (delay + 1) @(posedge clk);
                #1;
                bus_req_ready = 1'b1;
                @(posedge clk);
                #1;
                bus_req_ready = 1'b0;
                if (op != `L1_BUS_UPGR) begin
                    bus_fill.data   = fill_word(line_addr);
                    bus_fill.shared = fill_shared;
                    bus_fill_valid  = 1'b1;
                    @(posedge clk);
                    #1;
                    bus_fill_valid = 1'b0;
                end
            end
        end
    end

    initial begin : watchdog
        wait (loaded);
        #((steps.size() * 20 + 10) * 10);
        report_failure("timeout, the run did not reach its end");
    end

    initial begin : main
        reset          = 1'b1;
        core_req       = '0;
        core_req_valid = 1'b0;
        snoop_req      = '0;
        snoop_valid    = 1'b0;
        load_patterns();
        loaded = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        assert (core_req_ready) else report_failure("core_req_ready is low after reset");
        assert (!core_rsp_valid) else report_failure("core_rsp_valid is high after reset");
        for (int i = 0; i < steps.size(); i++) begin
            if (steps[i].is_snoop) begin
                present_snoop(i);
            end else begin
                issue_core_request(i);
            end
        end
        @(posedge clk);
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+rtl
rtl/l1_cache_pkg.sv
rtl/l1_line_store.sv
rtl/l1_lane_align.sv
rtl/l1_core_ctrl.sv
rtl/l1_snoop_ctrl.sv
rtl/l1_cache_top.sv
bench/l1_cache_assertions.sv
bench/l1_cache_tb.sv

//--- rtl/l1_cache_pkg.sv
`default_nettype none
`include "l1_consts.svh"

package l1_cache_pkg;

    typedef enum logic [1:0] {
        MESI_I = 2'b00,
        MESI_E = 2'b01,
        MESI_S = 2'b10,
        MESI_M = 2'b11
    } mesi_t;

    typedef enum logic {OP_LOAD = 1'b0, OP_STORE = 1'b1} mem_op_t;

    typedef enum logic [1:0] {SIZE_BYTE = 2'b00, SIZE_HALF = 2'b01, SIZE_WORD = 2'b10} size_t;

    typedef struct packed {
        logic  is_unsigned;   // Zero extend on load
        size_t size;
    } access_mask_t;

    typedef enum logic [1:0] {
        BUS_RD   = `L1_BUS_RD,
        BUS_UPGR = `L1_BUS_UPGR,
        BUS_RDX  = `L1_BUS_RDX,
        BUS_NONE = `L1_BUS_NONE
    } bus_op_t;

    typedef struct packed {
        mem_op_t                op;
        access_mask_t           mask;
        logic [`L1_ADDR_W-1:0]  addr;
        logic [`L1_DATA_W-1:0]  wdata;
    } core_req_t;

    typedef struct packed {
        logic [`L1_DATA_W-1:0] rdata;
    } core_rsp_t;

    typedef struct packed {
        mesi_t                 state;
        logic [`L1_TAG_W-1:0]  tag;
        logic [`L1_DATA_W-1:0] data;
    } line_t;

    typedef struct packed {
        bus_op_t               op;
        logic [`L1_ADDR_W-1:0] addr;
    } bus_req_t;

    typedef struct packed {
        logic [`L1_DATA_W-1:0] data;
        logic                  shared;   // Another cache holds the line
    } bus_fill_t;

    typedef struct packed {
        bus_op_t               op;
        logic [`L1_ADDR_W-1:0] addr;
    } snoop_req_t;

    typedef struct packed {
        logic                  hit;
        logic [`L1_DATA_W-1:0] data;
    } snoop_rsp_t;

    // Line address is tag and index, no byte offset
    typedef struct packed {
        logic [`L1_TAG_W+`L1_INDEX_W-1:0] line_addr;
        logic [`L1_DATA_W-1:0]            data;
    } flush_t;

endpackage

`default_nettype wire

//--- rtl/l1_cache_top.sv
`default_nettype none
`include "l1_consts.svh"

module l1_cache_top (
    input  logic                      clk,
    input  logic                      reset,
    input  l1_cache_pkg::core_req_t   core_req,
    input  logic                      core_req_valid,
    output logic                      core_req_ready,
    output l1_cache_pkg::core_rsp_t   core_rsp,
    output logic                      core_rsp_valid,
    output l1_cache_pkg::bus_req_t    bus_req,
    output logic                      bus_req_valid,
    input  logic                      bus_req_ready,
    input  l1_cache_pkg::bus_fill_t   bus_fill,
    input  logic                      bus_fill_valid,
    input  l1_cache_pkg::snoop_req_t  snoop_req,
    input  logic                      snoop_valid,
    output l1_cache_pkg::snoop_rsp_t  snoop_rsp,
    output l1_cache_pkg::flush_t      flush,
    output logic                      flush_valid
);
    import l1_cache_pkg::*;

    logic [`L1_INDEX_W-1:0] core_index;
    logic [`L1_INDEX_W-1:0] snoop_index;
    line_t                  core_line;
    line_t                  snoop_line;
    line_t                  core_wr_line;
    logic                   core_wr_en;
    logic                   snoop_wr_en;
    mesi_t                  snoop_wr_state;
    flush_t                 evict;
    logic                   evict_valid;

    l1_line_store u_line_store (
        .clk            (clk),
        .reset          (reset),
        .core_index     (core_index),
        .core_line      (core_line),
        .core_wr_en     (core_wr_en),
        .core_wr_line   (core_wr_line),
        .snoop_index    (snoop_index),
        .snoop_line     (snoop_line),
        .snoop_wr_en    (snoop_wr_en),
        .snoop_wr_state (snoop_wr_state)
    );

    l1_core_ctrl u_core_ctrl (
        .clk            (clk),
        .reset          (reset),
        .core_req       (core_req),
        .core_req_valid (core_req_valid),
        .core_req_ready (core_req_ready),
        .core_rsp       (core_rsp),
        .core_rsp_valid (core_rsp_valid),
        .bus_req        (bus_req),
        .bus_req_valid  (bus_req_valid),
        .bus_req_ready  (bus_req_ready),
        .bus_fill       (bus_fill),
        .bus_fill_valid (bus_fill_valid),
        .snoop_valid    (snoop_valid),
        .line           (core_line),
        .index          (core_index),
        .wr_en          (core_wr_en),
        .wr_line        (core_wr_line),
        .evict          (evict),
        .evict_valid    (evict_valid)
    );

    l1_snoop_ctrl u_snoop_ctrl (
        .snoop_req   (snoop_req),
        .snoop_valid (snoop_valid),
        .snoop_rsp   (snoop_rsp),
        .line        (snoop_line),
        .index       (snoop_index),
        .wr_en       (snoop_wr_en),
        .wr_state    (snoop_wr_state),
        .evict       (evict),
        .evict_valid (evict_valid),
        .flush       (flush),
        .flush_valid (flush_valid)
    );

endmodule

`default_nettype wire

//--- rtl/l1_consts.svh
`ifndef L1_CONSTS_SVH
`define L1_CONSTS_SVH

// Address split is tag | index | byte offset
`define L1_ADDR_W   32
`define L1_DATA_W   32
`define L1_TAG_W    24
`define L1_INDEX_W  6
`define L1_OFFSET_W 2
`define L1_LINES    64

// Shared bus operation codes
`define L1_BUS_RD   2'b00
`define L1_BUS_UPGR 2'b01
`define L1_BUS_RDX  2'b10
`define L1_BUS_NONE 2'b11

`endif

//--- rtl/l1_core_ctrl.sv
`default_nettype none
`include "l1_consts.svh"

module l1_core_ctrl (
    input  logic                      clk,
    input  logic                      reset,
    input  l1_cache_pkg::core_req_t   core_req,
    input  logic                      core_req_valid,
    output logic                      core_req_ready,
    output l1_cache_pkg::core_rsp_t   core_rsp,
    output logic                      core_rsp_valid,
    output l1_cache_pkg::bus_req_t    bus_req,
    output logic                      bus_req_valid,
    input  logic                      bus_req_ready,
    input  l1_cache_pkg::bus_fill_t   bus_fill,
    input  logic                      bus_fill_valid,
    input  logic                      snoop_valid,
    input  l1_cache_pkg::line_t       line,
    output logic [`L1_INDEX_W-1:0]    index,
    output logic                      wr_en,
    output l1_cache_pkg::line_t       wr_line,
    output l1_cache_pkg::flush_t      evict,
    output logic                      evict_valid
);
    import l1_cache_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_FILL} ctrl_state_t;

    ctrl_state_t           state_q;
    ctrl_state_t           state_d;
    core_req_t             req_q;
    core_req_t             cur_req;
    logic                  miss_q;
    logic                  accept;
    logic                  hit;
    logic                  rsp_fire;
    logic [`L1_DATA_W-1:0] rsp_data_d;
    logic [`L1_TAG_W-1:0]  cur_tag;
    logic [`L1_DATA_W-1:0] lane_word;
    logic [`L1_DATA_W-1:0] load_data;
    logic [`L1_DATA_W-1:0] merged_word;

    // Live request while idle, held copy afterwards
    assign cur_req = (state_q == ST_IDLE) ? core_req : req_q;
    assign cur_tag = cur_req.addr[`L1_ADDR_W-1 -: `L1_TAG_W];
    assign index   = cur_req.addr[`L1_OFFSET_W +: `L1_INDEX_W];
    assign hit     = (line.state != MESI_I) && (line.tag == cur_tag);

    // No new request until the response has gone out
    assign core_req_ready = (state_q == ST_IDLE) && !core_rsp_valid && !snoop_valid;
    assign accept         = core_req_valid && core_req_ready;

    assign lane_word = (state_q == ST_FILL) ? bus_fill.data : line.data;

    l1_lane_align u_lane_align (
        .mask        (cur_req.mask),
        .offset      (cur_req.addr[`L1_OFFSET_W-1:0]),
        .line_word   (lane_word),
        .store_data  (cur_req.wdata),
        .load_data   (load_data),
        .merged_word (merged_word)
    );

    assign bus_req_valid = (state_q == ST_REQ);
    assign bus_req.addr  = req_q.addr;

    always_comb begin
        bus_req.op = BUS_NONE;
        if (state_q == ST_REQ) begin
            if (!miss_q) begin
                bus_req.op = BUS_UPGR;           // Store hit on a Shared line
            end else if (req_q.op == OP_STORE) begin
                bus_req.op = BUS_RDX;
            end else begin
                bus_req.op = BUS_RD;
            end
        end
    end

    // Dirty victim goes out in the grant cycle
    assign evict.line_addr = {line.tag, index};
    assign evict.data      = line.data;
    assign evict_valid     = (state_q == ST_REQ) && bus_req_ready && miss_q
                             && (line.state == MESI_M);

    always_comb begin
        state_d       = state_q;
        wr_en         = 1'b0;
        rsp_fire      = 1'b0;
        rsp_data_d    = '0;
        wr_line.state = MESI_M;                  // Any store ends Modified
        wr_line.tag   = cur_tag;
        wr_line.data  = merged_word;
        case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    if (!hit || (core_req.op == OP_STORE && line.state == MESI_S)) begin
                        state_d = ST_REQ;
                    end else if (core_req.op == OP_LOAD) begin
                        rsp_fire   = 1'b1;
                        rsp_data_d = load_data;
                    end else begin
                        wr_en    = 1'b1;         // Silent E/M to M
                        rsp_fire = 1'b1;
                    end
                end
            end
            ST_REQ: begin
                if (bus_req_ready) begin
                    if (miss_q) begin
                        state_d = ST_FILL;
                    end else begin
                        wr_en    = 1'b1;
                        rsp_fire = 1'b1;
                        state_d  = ST_IDLE;
                    end
                end
            end
            ST_FILL: begin
                if (bus_fill_valid) begin
                    wr_en    = 1'b1;
                    rsp_fire = 1'b1;
                    state_d  = ST_IDLE;
                    if (req_q.op == OP_LOAD) begin
                        wr_line.state = bus_fill.shared ? MESI_S : MESI_E;
                        wr_line.data  = bus_fill.data;
                        rsp_data_d    = load_data;
                    end
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q        <= ST_IDLE;
            miss_q         <= 1'b0;
            core_rsp_valid <= 1'b0;
        end else begin
            state_q        <= state_d;
            core_rsp_valid <= rsp_fire;
            if (accept) begin
                miss_q <= !hit;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= core_req;
        end
        core_rsp.rdata <= rsp_data_d;
    end

endmodule

`default_nettype wire

//--- rtl/l1_lane_align.sv
`default_nettype none
`include "l1_consts.svh"

module l1_lane_align (
    input  l1_cache_pkg::access_mask_t mask,
    input  logic [`L1_OFFSET_W-1:0]    offset,
    input  logic [`L1_DATA_W-1:0]      line_word,
    input  logic [`L1_DATA_W-1:0]      store_data,
    output logic [`L1_DATA_W-1:0]      load_data,
    output logic [`L1_DATA_W-1:0]      merged_word
);
    import l1_cache_pkg::*;

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    assign sel_byte = line_word[{offset, 3'b000} +: 8];
    assign sel_half = line_word[{offset[1], 4'b0000} +: 16];   // Low offset bit ignored

    // Load side
    always_comb begin
        case (mask.size)
            SIZE_BYTE: begin
                load_data = mask.is_unsigned ? {24'b0, sel_byte} : {{24{sel_byte[7]}}, sel_byte};
            end
            SIZE_HALF: begin
                load_data = mask.is_unsigned ? {16'b0, sel_half}
                                             : {{16{sel_half[15]}}, sel_half};
            end
            default: load_data = line_word;
        endcase
    end

    // Store side, untouched lanes keep the line word
    always_comb begin
        merged_word = line_word;
        case (mask.size)
            SIZE_BYTE: merged_word[{offset, 3'b000} +: 8] = store_data[7:0];
            SIZE_HALF: merged_word[{offset[1], 4'b0000} +: 16] = store_data[15:0];
            default:   merged_word = store_data;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/l1_line_store.sv
`default_nettype none
`include "l1_consts.svh"

module l1_line_store (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`L1_INDEX_W-1:0]    core_index,
    output l1_cache_pkg::line_t       core_line,
    input  logic                      core_wr_en,
    input  l1_cache_pkg::line_t       core_wr_line,
    input  logic [`L1_INDEX_W-1:0]    snoop_index,
    output l1_cache_pkg::line_t       snoop_line,
    input  logic                      snoop_wr_en,
    input  l1_cache_pkg::mesi_t       snoop_wr_state
);
    import l1_cache_pkg::*;

    mesi_t                 state_q [`L1_LINES];
    logic [`L1_TAG_W-1:0]  tag_q   [`L1_LINES];
    logic [`L1_DATA_W-1:0] data_q  [`L1_LINES];

    // Two asynchronous read ports
    always_comb begin
        core_line.state  = state_q[core_index];
        core_line.tag    = tag_q[core_index];
        core_line.data   = data_q[core_index];
        snoop_line.state = state_q[snoop_index];
        snoop_line.tag   = tag_q[snoop_index];
        snoop_line.data  = data_q[snoop_index];
    end

    // Core and snoop writes never collide
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `L1_LINES; i++) begin
                state_q[i] <= MESI_I;
            end
        end else if (core_wr_en) begin
            state_q[core_index] <= core_wr_line.state;
        end else if (snoop_wr_en) begin
            state_q[snoop_index] <= snoop_wr_state;   // State only, tag and data kept
        end
    end

    always_ff @(posedge clk) begin
        if (core_wr_en) begin
            tag_q[core_index]  <= core_wr_line.tag;
            data_q[core_index] <= core_wr_line.data;
        end
    end

endmodule

`default_nettype wire

//--- rtl/l1_snoop_ctrl.sv
`default_nettype none
`include "l1_consts.svh"

module l1_snoop_ctrl (
    input  l1_cache_pkg::snoop_req_t snoop_req,
    input  logic                     snoop_valid,
    output l1_cache_pkg::snoop_rsp_t snoop_rsp,
    input  l1_cache_pkg::line_t      line,
    output logic [`L1_INDEX_W-1:0]   index,
    output logic                     wr_en,
    output l1_cache_pkg::mesi_t      wr_state,
    input  l1_cache_pkg::flush_t     evict,
    input  logic                     evict_valid,
    output l1_cache_pkg::flush_t     flush,
    output logic                     flush_valid
);
    import l1_cache_pkg::*;

    logic snoop_hit;
    logic snoop_flush;

    assign index     = snoop_req.addr[`L1_OFFSET_W +: `L1_INDEX_W];
    assign snoop_hit = snoop_valid && (line.state != MESI_I)
                       && (line.tag == snoop_req.addr[`L1_ADDR_W-1 -: `L1_TAG_W]);

    assign snoop_rsp.hit  = snoop_hit;
    assign snoop_rsp.data = snoop_hit ? line.data : '0;

    // Bus side MESI transitions
    always_comb begin
        wr_en       = 1'b0;
        wr_state    = line.state;
        snoop_flush = 1'b0;
        if (snoop_hit) begin
            case (snoop_req.op)
                BUS_RD: begin
                    wr_en       = (line.state == MESI_M) || (line.state == MESI_E);
                    wr_state    = MESI_S;
                    snoop_flush = (line.state == MESI_M);
                end
                BUS_UPGR: begin
                    wr_en    = 1'b1;
                    wr_state = MESI_I;
                end
                BUS_RDX: begin
                    wr_en       = 1'b1;
                    wr_state    = MESI_I;
                    snoop_flush = (line.state == MESI_M);
                end
                default: wr_en = 1'b0;
            endcase
        end
    end

    // Snoop write-back wins, core eviction otherwise
    assign flush.line_addr = snoop_flush ? {line.tag, index} : evict.line_addr;
    assign flush.data      = snoop_flush ? line.data : evict.data;
    assign flush_valid     = snoop_flush || evict_valid;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the L1 cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module l1_cache_tb -o l1_cache_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/l1_cache_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit "$status"
fi
exit 0
